//--- Bender.yml
package:
  name: lutnet_mnist

sources:
  - hw/lutnet_pkg.sv
  - hw/credit_fifo.sv
  - hw/lut_layer.sv
  - hw/lut_net_core.sv
  - hw/class_vote.sv
  - hw/lutnet_mnist_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/lutnet_mnist_props.sv
      - verification/lutnet_mnist_tb.sv

//--- hw/class_vote.sv
`timescale 1ns/1ps
`default_nettype none

module class_vote
	(
		input  logic                                clk,
		input  logic                                reset,

		input  logic                                in_valid,
		input  logic [lutnet_pkg::TAG_W-1:0]        in_tag,
		input  logic [lutnet_pkg::LAYER_W[3]-1:0]   in_data,

		output logic                                res_valid,
		output lutnet_pkg::net_res_t                res
	);

	logic [lutnet_pkg::N_CLASS-1:0][lutnet_pkg::VOTE_W-1:0] score;
	logic [lutnet_pkg::VOTE_W-1:0]                          best;
	logic [lutnet_pkg::CLASS_W-1:0]                         win;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scores and winner
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// class k owns bits 3k .. 3k+2
	always_comb begin
		for (int k = 0; k < lutnet_pkg::N_CLASS; k++) begin
			score[k] = lutnet_pkg::VOTE_W'(in_data[3*k])
				+ lutnet_pkg::VOTE_W'(in_data[3*k+1])
				+ lutnet_pkg::VOTE_W'(in_data[3*k+2]);
		end
	end

	// strict compare keeps the lowest index on a tie
	always_comb begin
		best = '0;
		win  = '0;
		for (int k = 0; k < lutnet_pkg::N_CLASS; k++) begin
			if (score[k] > best) begin
				best = score[k];
				win  = lutnet_pkg::CLASS_W'(k);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		res.tag       <= in_tag;
		res.class_idx <= win;
		res.score     <= score;
	end

endmodule

`default_nettype wire

//--- hw/credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo
	#(
		parameter type T          = logic [7:0],
		parameter int  DEPTH      = 4,
		parameter int  RD_CREDITS = 4
	)
	(
		input  logic clk,
		input  logic reset,

		input  logic wr_valid,
		input  T     wr_data,
		output logic wr_credit,

		output logic rd_valid,
		output T     rd_data,
		input  logic rd_credit
	);

	localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W  = $clog2(DEPTH + 1);
	localparam int CRED_W = $clog2(RD_CREDITS + 1);

	T                   mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic [CRED_W-1:0]  rd_cred;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// head leaves only while the reader has granted a slot
	assign rd_valid = (count != '0) && (rd_cred != '0);
	assign rd_data  = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_valid) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			rd_cred   <= CRED_W'(RD_CREDITS);
			wr_credit <= 1'b0;
		end else begin
			if (wr_valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (rd_valid) begin
				rd_ptr <= ptr_next(rd_ptr);
			end

			case ({wr_valid, rd_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			// a returned credit and a spent one in the same cycle cancel
			case ({rd_credit, rd_valid})
				2'b10:   rd_cred <= rd_cred + 1'b1;
				2'b01:   rd_cred <= rd_cred - 1'b1;
				default: rd_cred <= rd_cred;
			endcase

			// slot freed, hand it back to the writer
			wr_credit <= rd_valid;
		end
	end

endmodule

`default_nettype wire

//--- hw/lut_layer.sv
`timescale 1ns/1ps
`default_nettype none

module lut_layer
	#(
		parameter int                                  IN_W  = 64,
		parameter int                                  OUT_W = 256,
		parameter logic [2**lutnet_pkg::LUT_IN-1:0]    TABLE = '0
	)
	(
		input  logic             clk,
		input  logic             reset,

		input  logic [IN_W-1:0]  in_data,
		output logic [OUT_W-1:0] out_data
	);

	logic [OUT_W-1:0] node_out;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// nodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar j = 0; j < OUT_W; j++) begin : g_node
		logic [lutnet_pkg::LUT_IN-1:0] addr;

		// input m lands on address bit m
		for (genvar m = 0; m < lutnet_pkg::LUT_IN; m++) begin : g_in
			assign addr[m] = in_data[lutnet_pkg::lut_src(j, m, IN_W)];
		end

		assign node_out[j] = TABLE[addr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_data <= '0;
		end else begin
			out_data <= node_out;
		end
	end

endmodule

`default_nettype wire

//--- hw/lut_net_core.sv
`timescale 1ns/1ps
`default_nettype none

module lut_net_core
	(
		input  logic                                clk,
		input  logic                                reset,

		input  logic                                in_valid,
		input  lutnet_pkg::net_req_t                in_req,

		output logic                                out_valid,
		output logic [lutnet_pkg::TAG_W-1:0]        out_tag,
		output logic [lutnet_pkg::LAYER_W[3]-1:0]   out_data
	);

	localparam int N_STAGE = 4;

	logic [lutnet_pkg::LAYER_W[0]-1:0] layer0_data;
	logic [lutnet_pkg::LAYER_W[1]-1:0] layer1_data;
	logic [lutnet_pkg::LAYER_W[2]-1:0] layer2_data;
	logic [lutnet_pkg::LAYER_W[3]-1:0] layer3_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// layers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	lut_layer #(
		.IN_W  (lutnet_pkg::PIX_W),
		.OUT_W (lutnet_pkg::LAYER_W[0]),
		.TABLE (lutnet_pkg::LUT_TABLE[0])
	) lut_layer0_i (
		.clk      (clk),
		.reset    (reset),
		.in_data  (in_req.pix),
		.out_data (layer0_data)
	);

	lut_layer #(
		.IN_W  (lutnet_pkg::LAYER_W[0]),
		.OUT_W (lutnet_pkg::LAYER_W[1]),
		.TABLE (lutnet_pkg::LUT_TABLE[1])
	) lut_layer1_i (
		.clk      (clk),
		.reset    (reset),
		.in_data  (layer0_data),
		.out_data (layer1_data)
	);

	lut_layer #(
		.IN_W  (lutnet_pkg::LAYER_W[1]),
		.OUT_W (lutnet_pkg::LAYER_W[2]),
		.TABLE (lutnet_pkg::LUT_TABLE[2])
	) lut_layer2_i (
		.clk      (clk),
		.reset    (reset),
		.in_data  (layer1_data),
		.out_data (layer2_data)
	);

	lut_layer #(
		.IN_W  (lutnet_pkg::LAYER_W[2]),
		.OUT_W (lutnet_pkg::LAYER_W[3]),
		.TABLE (lutnet_pkg::LUT_TABLE[3])
	) lut_layer3_i (
		.clk      (clk),
		.reset    (reset),
		.in_data  (layer2_data),
		.out_data (layer3_data)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// valid and tag follow the data, one stage per layer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [N_STAGE-1:0]            valid_pipe;
	logic [lutnet_pkg::TAG_W-1:0]  tag_pipe [N_STAGE];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[N_STAGE-2:0], in_valid};
		end
	end

	always_ff @(posedge clk) begin
		tag_pipe[0] <= in_req.tag;
		for (int i = 1; i < N_STAGE; i++) begin
			tag_pipe[i] <= tag_pipe[i-1];
		end
	end

	assign out_valid = valid_pipe[N_STAGE-1];
	assign out_tag   = tag_pipe[N_STAGE-1];
	assign out_data  = layer3_data;

endmodule

`default_nettype wire

//--- hw/lutnet_mnist_top.sv
`timescale 1ns/1ps
`default_nettype none

module lutnet_mnist_top
	#(
		parameter int IN_DEPTH    = 4,
		parameter int OUT_DEPTH   = 8,
		parameter int OUT_CREDITS = 2
	)
	(
		input  logic                  clk,
		input  logic                  reset,

		input  logic                  in_valid,
		input  lutnet_pkg::net_req_t  in_req,
		output logic                  in_credit,

		output logic                  out_valid,
		output lutnet_pkg::net_res_t  out_res,
		input  logic                  out_credit
	);

	logic                                core_in_valid;
	lutnet_pkg::net_req_t                core_in_req;
	logic                                core_out_valid;
	logic [lutnet_pkg::TAG_W-1:0]        core_out_tag;
	logic [lutnet_pkg::LAYER_W[3]-1:0]   core_out_data;
	logic                                res_valid;
	lutnet_pkg::net_res_t                res;
	logic                                slot_free;

	// a request leaves only with a reserved output slot, so nothing downstream stalls
	credit_fifo #(
		.T          (lutnet_pkg::net_req_t),
		.DEPTH      (IN_DEPTH),
		.RD_CREDITS (OUT_DEPTH)
	) req_fifo_i (
		.clk       (clk),
		.reset     (reset),
		.wr_valid  (in_valid),
		.wr_data   (in_req),
		.wr_credit (in_credit),
		.rd_valid  (core_in_valid),
		.rd_data   (core_in_req),
		.rd_credit (slot_free)
	);

	lut_net_core lut_net_core_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (core_in_valid),
		.in_req    (core_in_req),
		.out_valid (core_out_valid),
		.out_tag   (core_out_tag),
		.out_data  (core_out_data)
	);

	class_vote class_vote_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (core_out_valid),
		.in_tag    (core_out_tag),
		.in_data   (core_out_data),
		.res_valid (res_valid),
		.res       (res)
	);

	credit_fifo #(
		.T          (lutnet_pkg::net_res_t),
		.DEPTH      (OUT_DEPTH),
		.RD_CREDITS (OUT_CREDITS)
	) res_fifo_i (
		.clk       (clk),
		.reset     (reset),
		.wr_valid  (res_valid),
		.wr_data   (res),
		.wr_credit (slot_free),
		.rd_valid  (out_valid),
		.rd_data   (out_res),
		.rd_credit (out_credit)
	);

endmodule

`default_nettype wire

//--- hw/lutnet_pkg.sv
package lutnet_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int TAG_W   = 8;
	localparam int PIX_W   = 64;
	localparam int N_CLASS = 10;
	localparam int VOTE_W  = 2;
	localparam int CLASS_W = 4;

	// six inputs per node, so every truth table is 64 bits
	localparam int LUT_IN = 6;

	localparam int LAYER_W [4] = '{256, 128, 60, 30};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// node wiring and truth tables
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int LUT_STRIDE_NODE  = 7;
	localparam int LUT_STRIDE_INPUT = 13;

	localparam logic [2**LUT_IN-1:0] LUT_TABLE [4] = '{
		64'h7E3C_A55A_18E7_C3D2,
		64'hB4D2_693C_E10F_5A87,
		64'h96E8_17A5_C36B_4D1E,
		64'h3FC0_A9D4_5B62_E817
	};

	// source bit of input m for node j, taken from a layer input of in_w bits
	function automatic int lut_src(input int node, input int m, input int in_w);
		return (LUT_STRIDE_NODE * node + LUT_STRIDE_INPUT * m) % in_w;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [PIX_W-1:0] pix;
	} net_req_t;

	// score[k] is the vote count of class k
	typedef struct packed {
		logic [TAG_W-1:0]                tag;
		logic [CLASS_W-1:0]              class_idx;
		logic [N_CLASS-1:0][VOTE_W-1:0]  score;
	} net_res_t;

endpackage

//--- lutnet_mnist.f
+incdir+include
hw/lutnet_pkg.sv
hw/credit_fifo.sv
hw/lut_layer.sv
hw/lut_net_core.sv
hw/class_vote.sv
hw/lutnet_mnist_top.sv
verification/lutnet_mnist_props.sv
verification/lutnet_mnist_tb.sv

//--- verification/lutnet_mnist_props.sv
`timescale 1ns/1ps

module lutnet_mnist_props
	#(
		parameter int DEPTH      = 4,
		parameter int RD_CREDITS = 4
	)
	(
		input logic                              clk,
		input logic                              reset,
		input logic                              wr_valid,
		input logic [$clog2(DEPTH+1)-1:0]        count,
		input logic [$clog2(RD_CREDITS+1)-1:0]   rd_cred
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// credit fifo rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// credits beyond the grant would let a read through with no slot behind it
	read_credit_bounded: assert property (@(posedge clk) disable iff (reset)
		rd_cred <= RD_CREDITS)
		else $error("credit_fifo holds more read credits than were granted");

	occupancy_in_range: assert property (@(posedge clk) disable iff (reset)
		count <= DEPTH)
		else $error("credit_fifo occupancy above depth");

	// the writer's credits keep a full buffer from being written
	no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		wr_valid |-> (count != DEPTH))
		else $error("credit_fifo written while full");

endmodule

bind credit_fifo lutnet_mnist_props #(
	.DEPTH      (DEPTH),
	.RD_CREDITS (RD_CREDITS)
) props_i (
	.clk      (clk),
	.reset    (reset),
	.wr_valid (wr_valid),
	.count    (count),
	.rd_cred  (rd_cred)
);

//--- include/lutnet_ref_model.svh
`ifndef LUTNET_REF_MODEL_SVH
`define LUTNET_REF_MODEL_SVH

// one layer with inputs and outputs packed into the widest layer vector
function automatic logic [lutnet_pkg::LAYER_W[0]-1:0] ref_layer(
		input logic [lutnet_pkg::LAYER_W[0]-1:0] in_bits, input int in_w,
		input int out_w, input logic [2**lutnet_pkg::LUT_IN-1:0] tbl);
	logic [lutnet_pkg::LAYER_W[0]-1:0] out_bits;
	logic [lutnet_pkg::LUT_IN-1:0]     addr;
	int                                src;
	out_bits = '0;
	for (int j = 0; j < out_w; j++) begin
		for (int m = 0; m < lutnet_pkg::LUT_IN; m++) begin
			src     = lutnet_pkg::LUT_STRIDE_NODE * j + lutnet_pkg::LUT_STRIDE_INPUT * m;
			addr[m] = in_bits[src % in_w];
		end
		out_bits[j] = tbl[addr];
	end
	return out_bits;
endfunction

function automatic logic [lutnet_pkg::LAYER_W[3]-1:0] ref_net(
		input logic [lutnet_pkg::PIX_W-1:0] pix);
	logic [lutnet_pkg::LAYER_W[0]-1:0] bits;
	int                                in_w;
	bits = lutnet_pkg::LAYER_W[0]'(pix);
	for (int i = 0; i < 4; i++) begin
		in_w = (i == 0) ? lutnet_pkg::PIX_W : lutnet_pkg::LAYER_W[i-1];
		bits = ref_layer(bits, in_w, lutnet_pkg::LAYER_W[i], lutnet_pkg::LUT_TABLE[i]);
	end
	return bits[lutnet_pkg::LAYER_W[3]-1:0];
endfunction

// winner is the lowest class among those with the top score
function automatic lutnet_pkg::net_res_t ref_result(
		input logic [lutnet_pkg::TAG_W-1:0] tag,
		input logic [lutnet_pkg::PIX_W-1:0] pix);
	lutnet_pkg::net_res_t              r;
	logic [lutnet_pkg::LAYER_W[3]-1:0] votes;
	int                                best;
	votes       = ref_net(pix);
	best        = 0;
	r.tag       = tag;
	r.class_idx = '0;
	for (int k = 0; k < lutnet_pkg::N_CLASS; k++) begin
		r.score[k] = votes[3*k] + votes[3*k+1] + votes[3*k+2];
		if (int'(r.score[k]) > best) begin
			best        = r.score[k];
			r.class_idx = lutnet_pkg::CLASS_W'(k);
		end
	end
	return r;
endfunction

`endif

//--- verification/lutnet_mnist_tb.sv
`timescale 1ns/1ps

module lutnet_mnist_tb;

	localparam int N_ROWS      = 17;
	localparam int N_FIXED     = 5;
	localparam int IN_DEPTH    = 4;
	localparam int OUT_CREDITS = 2;
	localparam int HOLD_AFTER  = 4;
	localparam int HOLD_LEN    = 120;
	localparam int TIMEOUT     = 40 * N_ROWS + 300;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	lutnet_pkg::net_req_t  in_req;
	logic                  in_credit;
	logic                  out_valid;
	lutnet_pkg::net_res_t  out_res;
	logic                  out_credit;

	// stimulus and expected result per row with the row index as tag
	string                          row_name [N_ROWS];
	logic [lutnet_pkg::PIX_W-1:0]   row_pix  [N_ROWS];
	lutnet_pkg::net_res_t           row_exp  [N_ROWS];

	int exp_row_q [$];
	int up_credits;
	int up_returned;
	int sent;
	int received;
	int valid_cycles;
	int down_outstanding;
	int down_returned;
	int hold_end;
	int cycle;
	int error_count;

	`include "lutnet_ref_model.svh"

	lutnet_mnist_top lutnet_mnist_top_i (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_res    (out_res),
		.out_credit (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic stop_run(input string what);
		error_count++;
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_res(input string name, input lutnet_pkg::net_res_t exp,
			input lutnet_pkg::net_res_t act);
		string msg;
		if (act !== exp) begin
			msg = $sformatf("Fail %s expected tag=%0d class=%0d score=%h", name, exp.tag,
				exp.class_idx, exp.score);
			msg = {msg, $sformatf(" actual tag=%0d class=%0d score=%h", act.tag,
				act.class_idx, act.score)};
			stop_run(msg);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			stop_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus, driver and consumer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic build_table();
		row_name[0] = "all_zeros";
		row_pix[0]  = 64'h0000_0000_0000_0000;
		row_name[1] = "all_ones";
		row_pix[1]  = 64'hFFFF_FFFF_FFFF_FFFF;
		row_name[2] = "stripes";
		row_pix[2]  = 64'hFF00_FF00_FF00_FF00;
		row_name[3] = "checkerboard";
		row_pix[3]  = 64'hAA55_AA55_AA55_AA55;
		row_name[4] = "hot_pixel";
		row_pix[4]  = 64'h0000_0010_0000_0000;
		for (int i = N_FIXED; i < N_ROWS; i++) begin
			row_name[i] = $sformatf("random_%0d", i - N_FIXED);
			row_pix[i]  = {$urandom, $urandom};
		end
		for (int i = 0; i < N_ROWS; i++) begin
			row_exp[i] = ref_result(lutnet_pkg::TAG_W'(i), row_pix[i]);
		end
	endtask

	task automatic observe_outputs();
		int row;
		if (in_credit) begin
			if (up_returned >= sent) begin
				stop_run("in_credit pulsed with no request outstanding");
			end else begin
				up_returned++;
				up_credits++;
			end
		end
		if (out_valid) begin
			valid_cycles++;
			if (valid_cycles > OUT_CREDITS + down_returned) begin
				stop_run("out_valid asserted without a downstream credit");
			end else if (exp_row_q.size() == 0) begin
				stop_run("out_valid asserted with no result expected");
			end else begin
				row = exp_row_q.pop_front();
				check_res(row_name[row], row_exp[row], out_res);
				received++;
				down_outstanding--;
			end
		end
	endtask

	task automatic drive_inputs();
		if (sent < N_ROWS && up_credits > 0) begin
			in_valid   = 1'b1;
			in_req.tag = lutnet_pkg::TAG_W'(sent);
			in_req.pix = row_pix[sent];
			exp_row_q.push_back(sent);
			up_credits--;
			sent++;
		end else begin
			in_valid = 1'b0;
			in_req   = '0;
		end
	endtask

	// consumer buffer holds OUT_CREDITS results and frees them at random
	task automatic return_credit();
		if (received == HOLD_AFTER && hold_end == 0) begin
			hold_end = cycle + HOLD_LEN;
		end
		out_credit = 1'b0;
		if (cycle >= hold_end && down_outstanding < OUT_CREDITS && ($urandom % 4) != 0) begin
			out_credit = 1'b1;
			down_outstanding++;
			down_returned++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		void'($urandom(23501));
		reset            = 1'b1;
		in_valid         = 1'b0;
		in_req           = '0;
		out_credit       = 1'b0;
		up_credits       = IN_DEPTH;
		up_returned      = 0;
		sent             = 0;
		received         = 0;
		valid_cycles     = 0;
		down_outstanding = OUT_CREDITS;
		down_returned    = 0;
		hold_end         = 0;
		cycle            = 0;
		error_count      = 0;
		build_table();

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
			stop_run("out_valid or in_credit high right after reset");
		end

		while (received < N_ROWS) begin
			@(negedge clk);
			cycle++;
			if (cycle > TIMEOUT) begin
				stop_run("timeout, not all results arrived");
			end
			observe_outputs();
			drive_inputs();
			return_credit();
		end

		// idle tail catches any stray result or credit pulse
		repeat (20) begin
			@(negedge clk);
			cycle++;
			observe_outputs();
			drive_inputs();
			return_credit();
		end

		check_count("upstream_credits", N_ROWS, up_returned);

		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
